/* hdl/bitscan_pkg.sv */
package bitscan_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths of the scan datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int OPERAND_W  = 32;                     // scanned word, old destination and result
    localparam int INDEX_W    = 5;                      // bit position within an operand
    localparam int GROUP_SIZE = 8;                      // bits per byte group encoder
    localparam int GROUP_W    = 3;                      // position within one byte group
    localparam int NUM_GROUPS = OPERAND_W / GROUP_SIZE; // byte groups in one operand

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [INDEX_W-1:0]   bit_index_t;
    typedef logic [GROUP_W-1:0]   group_index_t;

    // one opcode bit selects the scan direction
    typedef logic scan_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam scan_op_t OP_BSF = 1'b0; // search from bit 0 upward
    localparam scan_op_t OP_BSR = 1'b1; // search from bit 31 downward

endpackage

/* hdl/bitscan_top.sv */
`timescale 1ns/1ps

module bitscan_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  bitscan_pkg::scan_op_t in_op,
    input  bitscan_pkg::operand_t in_operand,
    input  bitscan_pkg::operand_t in_dest,
    output logic                  out_valid,
    output bitscan_pkg::operand_t out_result,
    output logic                  out_zf
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1 holds the operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                  s1_valid;   // an operation sits in stage 1
    bitscan_pkg::scan_op_t s1_op;      // scan direction
    bitscan_pkg::operand_t s1_operand; // word to scan
    bitscan_pkg::operand_t s1_dest;    // destination value kept on a zero operand

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_op      <= in_op;
            s1_operand <= in_operand;
            s1_dest    <= in_dest;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // direction conditioning and encode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                    is_bsr;       // scanning from the top bit down
    bitscan_pkg::operand_t   reversed;     // operand with bit i moved to 31 - i
    bitscan_pkg::operand_t   scan_word;    // what the lowest-first encoder sees
    bitscan_pkg::bit_index_t enc_index;    // lowest set position of scan_word
    logic                    enc_found;    // scan_word is nonzero
    bitscan_pkg::bit_index_t scan_index;   // position in the original operand

    assign is_bsr = (s1_op == bitscan_pkg::OP_BSR);

    always_comb begin
        for (int i = 0; i < bitscan_pkg::OPERAND_W; i++) begin
            reversed[i] = s1_operand[bitscan_pkg::OPERAND_W-1-i];
        end
    end

    // BSR is the lowest set bit of the reversed word
    assign scan_word = is_bsr ? reversed : s1_operand;

    pencoder32_5 u_pencoder (
        .in_bits (scan_word),
        .index   (enc_index),
        .found   (enc_found)
    );

    // complementing five bits maps position p back to 31 - p
    assign scan_index = is_bsr ? ~enc_index : enc_index;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result merge and stage 2
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    bitscan_pkg::operand_t merged_result; // value headed for out_result

    // A zero operand leaves the destination unchanged and raises the zero flag.
    // Otherwise the index is zero-extended to the full word.
    assign merged_result = enc_found ? bitscan_pkg::operand_t'(scan_index) : s1_dest;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;  // two edges after in_valid was sampled
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_result <= merged_result;
            out_zf     <= ~enc_found;
        end
    end

endmodule

/* hdl/pencoder32_5.sv */
`timescale 1ns/1ps

module pencoder32_5 (
    input  bitscan_pkg::operand_t   in_bits,
    output bitscan_pkg::bit_index_t index,
    output logic                    found
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // level one with one encoder per byte group
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    bitscan_pkg::group_index_t            byte_index [bitscan_pkg::NUM_GROUPS]; // in-group positions
    logic [bitscan_pkg::NUM_GROUPS-1:0]   byte_found;                           // byte has a set bit

    for (genvar g = 0; g < bitscan_pkg::NUM_GROUPS; g++) begin : g_byte
        pencoder8_3 u_byte (
            .in_bits (in_bits[g*bitscan_pkg::GROUP_SIZE +: bitscan_pkg::GROUP_SIZE]),
            .index   (byte_index[g]),
            .found   (byte_found[g])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // level two picks the lowest non-empty group
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [bitscan_pkg::GROUP_SIZE-1:0] group_bits; // one bit per byte group
    bitscan_pkg::group_index_t          group_sel;  // winning group number
    bitscan_pkg::group_index_t          low_index;  // position inside the winning group

    // only four groups exist, so the upper inputs of the group encoder stay empty
    assign group_bits = {4'b0000, byte_found};

    pencoder8_3 u_group (
        .in_bits (group_bits),
        .index   (group_sel),
        .found   (found)
    );

    // group_sel[2] is always zero here since the top four inputs are tied off
    always_comb begin
        case (group_sel[1:0])
            2'd0:    low_index = byte_index[0];
            2'd1:    low_index = byte_index[1];
            2'd2:    low_index = byte_index[2];
            default: low_index = byte_index[3];
        endcase
    end

    // The group number gives bits 4:3 and the in-group index bits 2:0.
    // With no bit set anywhere, group 0 and its zero index make the result zero.
    assign index = {group_sel[1:0], low_index};

endmodule

/* hdl/pencoder8_3.sv */
`timescale 1ns/1ps

module pencoder8_3 (
    input  logic [7:0]                in_bits,
    output bitscan_pkg::group_index_t index,
    output logic                      found
);

    // Lowest set bit wins. An empty byte reports index zero, which the
    // group select in pencoder32_5 depends on.
    always_comb begin
        found = 1'b1;                                           // cleared only by the empty case
        casez (in_bits)
            8'b???????1: index = bitscan_pkg::group_index_t'(0);
            8'b??????10: index = bitscan_pkg::group_index_t'(1);
            8'b?????100: index = bitscan_pkg::group_index_t'(2);
            8'b????1000: index = bitscan_pkg::group_index_t'(3);
            8'b???10000: index = bitscan_pkg::group_index_t'(4);
            8'b??100000: index = bitscan_pkg::group_index_t'(5);
            8'b?1000000: index = bitscan_pkg::group_index_t'(6);
            8'b10000000: index = bitscan_pkg::group_index_t'(7);
            default: begin
                index = bitscan_pkg::group_index_t'(0);         // no bit set in this byte
                found = 1'b0;
            end
        endcase
    end

endmodule

/* sim/bitscan_asserts.sv */
`timescale 1ns/1ps

module bitscan_asserts (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  in_valid,
    input logic                  out_valid,
    input logic                  out_zf,
    input bitscan_pkg::operand_t out_result,
    input bitscan_pkg::operand_t s1_dest
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset and pipeline timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the first rising edge in reset has cleared out_valid by the falling edge
    a_idle_in_reset: assert property (@(negedge clk) !arst_n |-> !out_valid)
        else $error("out_valid is high while arst_n is low");

    // two register stages between the strobe and the result
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two edges");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result merge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_zero_keeps_dest: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && out_zf) |-> (out_result == $past(s1_dest)))
        else $error("zero flag set but the result is not the old destination");

endmodule

bind bitscan_top bitscan_asserts u_asserts (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_zf     (out_zf),
    .out_result (out_result),
    .s1_dest    (s1_dest)
);

/* sim/bitscan_tb.sv */
`timescale 1ns/1ps

module bitscan_tb;

    localparam int    CLK_PERIOD   = 10;                      // ns
    localparam int    RESET_CYCLES = 5;
    localparam int    NUM_RANDOM   = 200;
    localparam string TESTS_FILE   = "sim/bitscan_tests.txt";

    typedef struct packed {
        bitscan_pkg::scan_op_t op;
        bitscan_pkg::operand_t operand;
        bitscan_pkg::operand_t dest;
        bitscan_pkg::operand_t result;
        logic                  zf;
    } vector_t;

    typedef struct packed {
        bitscan_pkg::scan_op_t op;
        bitscan_pkg::operand_t operand;
        bitscan_pkg::operand_t result;
        logic                  zf;
        int                    due;                           // edge count when the result shows
    } expect_t;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    bitscan_pkg::scan_op_t in_op;
    bitscan_pkg::operand_t in_operand;
    bitscan_pkg::operand_t in_dest;
    logic                  out_valid;
    bitscan_pkg::operand_t out_result;
    logic                  out_zf;

    vector_t vectors [$];
    expect_t expect_q [$];                                    // operations still in flight
    int      edge_count;
    int      pass_count;
    int      fail_count;
    int      test_pass_base;
    int      test_fail_base;
    bit      vectors_loaded;

    bitscan_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_operand (in_operand),
        .in_dest    (in_dest),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_zf     (out_zf)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) edge_count <= edge_count + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference scan and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic bitscan_pkg::operand_t scan_model(input bitscan_pkg::scan_op_t op,
                                                         input bitscan_pkg::operand_t operand,
                                                         input bitscan_pkg::operand_t dest);
        bitscan_pkg::operand_t result;
        bit                    hit;
        result = dest;                                        // a zero operand keeps the destination
        hit    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            // BSF stops at the first hit while BSR keeps moving up to the last one
            if (operand[i] && (!hit || op == bitscan_pkg::OP_BSR)) begin
                result = bitscan_pkg::operand_t'(i);
                hit    = 1'b1;
            end
        end
        return result;
    endfunction

    function automatic string op_name(input bitscan_pkg::scan_op_t op);
        return (op == bitscan_pkg::OP_BSR) ? "BSR" : "BSF";
    endfunction

    task automatic load_vectors();
        int                    fd;
        int                    n;
        int                    line_no;
        string                 line;
        bitscan_pkg::operand_t f_op;
        bitscan_pkg::operand_t f_operand;
        bitscan_pkg::operand_t f_dest;
        bitscan_pkg::operand_t f_result;
        bitscan_pkg::operand_t f_zf;
        vector_t               v;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open %s for reading", TESTS_FILE);
            fail_count++;
        end else begin
            line_no = 0;
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h", f_op, f_operand, f_dest, f_result, f_zf);
                if (n != 5) begin
                    continue;                                 // blank or short line
                end
                v.op      = f_op[0];
                v.operand = f_operand;
                v.dest    = f_dest;
                v.result  = f_result;
                v.zf      = f_zf[0];
                if (scan_model(v.op, v.operand, v.dest) !== v.result
                        || (v.operand == '0) !== v.zf) begin
                    $display("ERROR: line %0d of %s does not follow the scan rule",
                             line_no, TESTS_FILE);
                    fail_count++;
                end
                vectors.push_back(v);
            end
            $fclose(fd);
        end
        vectors_loaded = 1'b1;
    endtask

    task automatic issue_op(input bitscan_pkg::scan_op_t op, input bitscan_pkg::operand_t operand,
                            input bitscan_pkg::operand_t dest, input bitscan_pkg::operand_t result,
                            input logic zf);
        expect_t e;
        @(posedge clk);
        in_valid   <= 1'b1;
        in_op      <= op;
        in_operand <= operand;
        in_dest    <= dest;
        e.op      = op;
        e.operand = operand;
        e.result  = result;
        e.zf      = zf;
        e.due     = edge_count + 3;                           // sampled next edge and out two later
        expect_q.push_back(e);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);                                       // let out_valid fall once more
    endtask

    task automatic finish_test(input string name);
        $display("test %-16s done: %0d passed, %0d failed", name,
                 pass_count - test_pass_base, fail_count - test_fail_base);
        test_pass_base = pass_count;
        test_fail_base = fail_count;
    endtask

    task automatic run_random();
        bitscan_pkg::scan_op_t op;
        bitscan_pkg::operand_t operand;
        bitscan_pkg::operand_t dest;
        for (int k = 0; k < NUM_RANDOM; k++) begin
            op   = bitscan_pkg::scan_op_t'($urandom_range(0, 1));
            dest = $urandom;
            case ($urandom_range(0, 3))
                0: operand = $urandom;
                1: operand = $urandom & $urandom & $urandom;  // sparse word with a few bits
                2: operand = 32'h1 << $urandom_range(0, 31);
                default: begin
                    if ($urandom_range(0, 3) == 0) begin
                        operand = '0;
                    end else begin
                        operand = (32'h1 << $urandom_range(0, 31))
                                | (32'h1 << $urandom_range(0, 31));
                    end
                end
            endcase
            issue_op(op, operand, dest, scan_model(op, operand, dest), operand == '0);
            if ($urandom_range(0, 7) == 0) begin
                idle_cycle();                                 // occasional gap in the stream
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result monitor on the falling edge where outputs are stable
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin : result_monitor
        expect_t e;
        if (!arst_n) begin
            if (out_valid !== 1'b0) begin
                $display("CHECK FAILED at %0t: out_valid is %b during reset", $time, out_valid);
                fail_count++;
            end else begin
                pass_count++;
            end
        end else if (out_valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                $display("ERROR: a result arrived at %0t with no operation in flight", $time);
                fail_count++;
            end else begin
                e = expect_q.pop_front();
                if (edge_count != e.due) begin
                    $display("CHECK FAILED at %0t: %s of %h came at edge %0d, due at %0d",
                             $time, op_name(e.op), e.operand, edge_count, e.due);
                    fail_count++;
                end else if (out_result !== e.result || out_zf !== e.zf) begin
                    $display("CHECK FAILED at %0t: %s of %h gave %h zf %b, expected %h zf %b",
                             $time, op_name(e.op), e.operand, out_result, out_zf,
                             e.result, e.zf);
                    fail_count++;
                end else begin
                    pass_count++;
                end
            end
        end else if (expect_q.size() != 0 && expect_q[0].due <= edge_count) begin
            e = expect_q.pop_front();
            $display("ERROR: the result of %s on %h did not arrive two edges after issue",
                     op_name(e.op), e.operand);
            fail_count++;
        end else if (out_valid !== 1'b0) begin
            $display("CHECK FAILED at %0t: out_valid is %b on an idle cycle", $time, out_valid);
            fail_count++;
        end else begin
            pass_count++;                                     // idle cycle with nothing due
        end
    end

    initial begin : watchdog
        int limit_cycles;
        wait (vectors_loaded);
        limit_cycles = RESET_CYCLES + 3 * vectors.size() + 2 * NUM_RANDOM + 20;
        #(limit_cycles * CLK_PERIOD);
        $display("ERROR: timeout, the run did not finish within %0d cycles", limit_cycles);
        $display("Checks failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_op      = bitscan_pkg::OP_BSF;
        in_operand = '0;
        in_dest    = '0;
        void'($urandom(32'h18d7));
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) idle_cycle();
        finish_test("reset");

        foreach (vectors[i]) begin
            issue_op(vectors[i].op, vectors[i].operand, vectors[i].dest,
                     vectors[i].result, vectors[i].zf);
            idle_cycle();                                     // gap between operations
        end
        drain();
        finish_test("directed_spaced");

        foreach (vectors[i]) begin
            issue_op(vectors[i].op, vectors[i].operand, vectors[i].dest,
                     vectors[i].result, vectors[i].zf);
        end
        drain();
        finish_test("directed_stream");

        run_random();
        drain();
        finish_test("random");

        if (expect_q.size() != 0) begin
            $display("ERROR: %0d results never arrived", expect_q.size());
            fail_count++;
        end
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim/bitscan_tests.txt */
# columns in hex: opcode (0 BSF, 1 BSR), operand, old destination,
# expected result, expected zero flag
0 00000001 a5a5a5a5 00000000 0
1 00000001 a5a5a5a5 00000000 0
0 00000080 a5a5a5a5 00000007 0
1 00000080 a5a5a5a5 00000007 0
0 00000100 a5a5a5a5 00000008 0
1 00000100 a5a5a5a5 00000008 0
0 00008000 a5a5a5a5 0000000f 0
1 00008000 a5a5a5a5 0000000f 0
0 00010000 a5a5a5a5 00000010 0
1 00010000 a5a5a5a5 00000010 0
0 80000000 a5a5a5a5 0000001f 0
1 80000000 a5a5a5a5 0000001f 0
0 00018100 5a5a5a5a 00000008 0
1 00018100 5a5a5a5a 00000010 0
0 80000001 5a5a5a5a 00000000 0
1 80000001 5a5a5a5a 0000001f 0
0 00f00f00 5a5a5a5a 00000008 0
1 00f00f00 5a5a5a5a 00000017 0
0 12345678 5a5a5a5a 00000003 0
1 12345678 5a5a5a5a 0000001c 0
0 40000080 5a5a5a5a 00000007 0
1 40000080 5a5a5a5a 0000001e 0
0 01010000 5a5a5a5a 00000010 0
1 01010000 5a5a5a5a 00000018 0
0 00000000 deadbeef deadbeef 1
1 00000000 00000055 00000055 1
0 00000000 ffffffff ffffffff 1
1 00000000 13579bdf 13579bdf 1

/* sources.f */
hdl/bitscan_pkg.sv
hdl/pencoder8_3.sv
hdl/pencoder32_5.sv
hdl/bitscan_top.sv
sim/bitscan_asserts.sv
sim/bitscan_tb.sv
